//--- rtl/crop_pkg.sv
// video crop package with shared types, timing margins and key codes

package crop_pkg;

	////////////////////////////////////////////////////////////
	// basic types

	typedef logic [11:0] cnt_t;    // pixel, line or offset count
	typedef logic [1:0]  res_t;    // resolution code

	typedef struct packed {
		cnt_t left;                // moves start of active line
		cnt_t right;               // moves end of active line
		cnt_t top;                 // moves first active row
		cnt_t bottom;              // moves last active row
	} crop_offsets_t;

	typedef struct packed {
		logic       strobe;        // event strobe level
		logic [1:0] kind;          // event type
		logic [7:0] code;          // key code
	} key_event_t;

	typedef struct packed {
		crop_offsets_t offsets;    // offsets in use at capture
		cnt_t          hsize;      // active width
		cnt_t          vsize;      // active height, both fields
		res_t          res;        // resolution code
	} screen_info_t;

	////////////////////////////////////////////////////////////
	// timing margins and steps

	localparam cnt_t HFORCE_START = 12'd8;   // forced hblank ends here
	localparam cnt_t HFORCE_END   = 12'd8;   // forced hblank starts this far before hmax
	localparam cnt_t VFORCE_START = 12'd1;
	localparam cnt_t VFORCE_END   = 12'd3;
	localparam cnt_t HADJ         = 12'd2;   // pipeline skew on horizontal edges
	localparam cnt_t VADJ         = 12'd1;
	localparam cnt_t HSTEP        = 12'd4;   // left and right step
	localparam cnt_t VSTEP        = 12'd1;   // top and bottom step

	// keyboard events
	localparam logic [1:0] KIND_ADJUST  = 2'd3;
	localparam logic [7:0] KEY_BKSP     = 8'h41;
	localparam logic [7:0] KEY_UP       = 8'h4c;
	localparam logic [7:0] KEY_DOWN     = 8'h4d;
	localparam logic [7:0] KEY_LEFT     = 8'h4f;
	localparam logic [7:0] KEY_RIGHT    = 8'h4e;
	localparam logic [7:0] KEY_ALT_L_DN = 8'h64;
	localparam logic [7:0] KEY_ALT_R_DN = 8'h65;
	localparam logic [7:0] KEY_ALT_L_UP = 8'he4;
	localparam logic [7:0] KEY_ALT_R_UP = 8'he5;

endpackage

//--- rtl/hblank_shaper.sv
// horizontal blank shaper that measures each line and moves its blank edges
`timescale 1ns/1ps

module hblank_shaper import crop_pkg::*; (
	input  logic          clk_28,
	input  logic          RESET,
	input  logic          hsync_n,     // active low line sync
	input  logic          hblank,      // source horizontal blank
	input  crop_offsets_t offsets,     // left and right used here
	input  logic          hsize_take,  // width sample line, from vertical side
	output logic          hbl,         // combined horizontal blank
	output logic          hde,         // registered horizontal enable
	output logic          hcnt_end,    // pulse at sync fall
	output cnt_t          hsize        // measured active width
);

	logic old_hs;          // sync one cycle back
	logic old_hblank;      // hblank one cycle back
	logic hb_start;        // hblank going high
	logic hb_end;          // hblank going low
	cnt_t hcnt;            // pixels since sync
	cnt_t hend;            // hcnt where hblank ends
	cnt_t hsta;            // hcnt where hblank starts
	cnt_t hmax;            // hcnt at line end
	cnt_t shbl_open;       // shaped blank release point
	cnt_t shbl_close;      // shaped blank start point
	cnt_t fhbl_close;      // forced blank start point
	logic shbl;            // shaped blank
	logic fhbl;            // forced blank around sync

	assign hb_start   = ~old_hblank & hblank;
	assign hb_end     = old_hblank & ~hblank;
	assign hcnt_end   = old_hs & ~hsync_n;
	assign shbl_open  = hend + offsets.left - HADJ;
	assign shbl_close = hsta + offsets.right - HADJ;
	assign fhbl_close = hmax - HFORCE_END;
	assign hbl        = fhbl | shbl | ~hsync_n;   // sync always blanks

	////////////////////////////////////////////////////////////
	// line measurement and edge shaping

	always_ff @(posedge clk_28) begin
		if (!RESET) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b1;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			hsize      <= '0;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
			hde        <= 1'b0;
		end else begin
			old_hs     <= hsync_n;
			old_hblank <= hblank;
			hcnt       <= hsync_n ? hcnt + 12'd1 : '0;   // held at 0 in sync

			if (hb_end)   hend <= hcnt;
			if (hb_start) hsta <= hcnt;
			if (hcnt_end) hmax <= hcnt;                  // total line length
			if (hb_start && hsize_take) hsize <= hcnt - hend;

			if (hcnt == shbl_open)    shbl <= 1'b0;
			if (hcnt == shbl_close)   shbl <= 1'b1;
			if (hcnt == HFORCE_START) fhbl <= 1'b0;
			if (hcnt == fhbl_close)   fhbl <= 1'b1;

			hde <= ~hbl;
		end
	end

endmodule

//--- rtl/vblank_shaper.sv
// vertical blank shaper with field aware frame measurement and row cropping
`timescale 1ns/1ps

module vblank_shaper import crop_pkg::*; (
	input  logic          clk_28,
	input  logic          RESET,
	input  logic          vsync_n,     // active low frame sync
	input  logic          vblank,      // source vertical blank
	input  logic          field1,      // interlace field flag
	input  logic          hbl,         // combined horizontal blank
	input  logic          hcnt_end,    // line end pulse
	input  crop_offsets_t offsets,     // top and bottom used here
	output logic          vde,         // vertical display enable
	output logic          vbl_end,     // registered vblank fall pulse
	output cnt_t          vsize,       // active rows, both fields
	output logic          hsize_take   // width sample line
);

	logic vbl;             // vblank or sync
	logic old_vs;
	logic old_vbl;
	logic old_hbl;
	logic vs_fall;
	logic vbl_rise;
	logic vbl_fall;
	logic hbl_fall;        // start of active part of a line
	cnt_t vcnt;            // lines since sync
	cnt_t f0_vend;         // field 0 edges and length
	cnt_t f0_vsta;
	cnt_t f0_vmax;
	cnt_t f1_vend;         // field 1 edges and length
	cnt_t f1_vsta;
	cnt_t f1_vmax;
	cnt_t f1_vsize;        // field 1 height, waiting for field 0
	cnt_t vend;            // edges of the field on now
	cnt_t vsta;
	cnt_t vmax;
	logic svbl;            // shaped blank
	logic fvbl;            // forced blank near sync

	assign vbl        = vblank | ~vsync_n;
	assign vs_fall    = old_vs & ~vsync_n;
	assign vbl_rise   = ~old_vbl & vbl;
	assign vbl_fall   = old_vbl & ~vbl;
	assign hbl_fall   = old_hbl & ~hbl;
	assign vend       = field1 ? f1_vend : f0_vend;
	assign vsta       = field1 ? f1_vsta : f0_vsta;
	assign vmax       = field1 ? f1_vmax : f0_vmax;
	assign vde        = ~(svbl | fvbl);
	assign hsize_take = ~field1 & (vcnt == f0_vend + 12'd1);   // one line into active

	always_ff @(posedge clk_28) begin
		if (!RESET) begin
			old_vs   <= 1'b1;
			old_vbl  <= 1'b1;
			old_hbl  <= 1'b1;
			vbl_end  <= 1'b0;
			vcnt     <= '0;
			f0_vend  <= '0;
			f0_vsta  <= '0;
			f0_vmax  <= '0;
			f1_vend  <= '0;
			f1_vsta  <= '0;
			f1_vmax  <= '0;
			f1_vsize <= '0;
			vsize    <= '0;
			svbl     <= 1'b1;
			fvbl     <= 1'b1;
		end else begin
			old_vs  <= vsync_n;
			old_vbl <= vbl;
			old_hbl <= hbl;
			vbl_end <= vbl_fall;                 // one cycle late on purpose
			if (hcnt_end) vcnt <= vcnt + 12'd1;
			if (!vsync_n) vcnt <= '0;

			////////////////////////////////////////////////////////////
			// per field measurement
			if (!field1) begin
				if (vbl_fall) f0_vend <= vcnt;
				if (vs_fall)  f0_vmax <= vcnt;
				if (vbl_rise) begin
					f0_vsta  <= vcnt;
					vsize    <= vcnt - f0_vend + f1_vsize;   // adds previous field 1
					f1_vsize <= '0;
				end
			end else begin
				if (vbl_fall) f1_vend <= vcnt;
				if (vs_fall)  f1_vmax <= vcnt;
				if (vbl_rise) begin
					f1_vsta  <= vcnt;
					f1_vsize <= vcnt - f1_vend;
				end
			end

			// rows switch only where a line goes active
			if (hbl_fall) begin
				if (vcnt == vend + offsets.top - VADJ)    svbl <= 1'b0;
				if (vcnt == vsta + offsets.bottom - VADJ) svbl <= 1'b1;
				if (vcnt == VFORCE_START)                 fvbl <= 1'b0;
				if (vcnt == vmax - VFORCE_END)            fvbl <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/crop_keys.sv
// crop offset registers stepped by keyboard events or loaded from a preset
`timescale 1ns/1ps

module crop_keys import crop_pkg::*; (
	input  logic          clk_28,
	input  logic          RESET,
	input  key_event_t    key,          // keyboard event
	input  crop_offsets_t preset,       // full offset set
	input  logic          preset_load,  // level, loads every cycle
	output crop_offsets_t offsets
);

	logic       adj_stb;   // strobe of an adjust event
	logic       old_stb;
	logic       adj_rise;  // registered strobe edge
	logic [7:0] code_q;    // code aligned with adj_rise
	logic       alt;       // either alt held

	assign adj_stb = key.strobe & (key.kind == KIND_ADJUST);

	always_ff @(posedge clk_28) begin
		code_q <= key.code;
	end

	////////////////////////////////////////////////////////////
	// edge detect and offset update

	always_ff @(posedge clk_28) begin
		if (!RESET) begin
			old_stb  <= 1'b0;
			adj_rise <= 1'b0;
			alt      <= 1'b0;
			offsets  <= '0;
		end else begin
			old_stb  <= adj_stb;
			adj_rise <= adj_stb & ~old_stb;

			if (adj_rise) begin
				if (code_q == KEY_ALT_L_DN || code_q == KEY_ALT_R_DN) alt <= 1'b1;
				if (code_q == KEY_ALT_L_UP || code_q == KEY_ALT_R_UP) alt <= 1'b0;
			end

			if (preset_load) begin
				offsets <= preset;                     // wins over keys
			end else if (adj_rise) begin
				case (code_q)
					KEY_BKSP:  offsets <= '0;
					KEY_UP: begin
						if (alt) offsets.bottom <= offsets.bottom + VSTEP;
						else     offsets.top    <= offsets.top + VSTEP;
					end
					KEY_DOWN: begin
						if (alt) offsets.bottom <= offsets.bottom - VSTEP;
						else     offsets.top    <= offsets.top - VSTEP;
					end
					KEY_LEFT: begin
						if (alt) offsets.right <= offsets.right + HSTEP;
						else     offsets.left  <= offsets.left + HSTEP;
					end
					KEY_RIGHT: begin
						if (alt) offsets.right <= offsets.right - HSTEP;
						else     offsets.left  <= offsets.left - HSTEP;
					end
					default: ;                             // alt codes and others
				endcase
			end
		end
	end

endmodule

//--- rtl/screen_info.sv
// screen info capture at the end of vblank with a change counter
`timescale 1ns/1ps

module screen_info import crop_pkg::*; (
	input  logic          clk_28,
	input  logic          RESET,
	input  logic          vbl_end,     // capture strobe
	input  crop_offsets_t offsets,
	input  cnt_t          hsize,
	input  cnt_t          vsize,
	input  res_t          res,
	output screen_info_t  info,        // last captured record
	output logic [6:0]    info_count   // steps on size or mode change
);

	logic changed;   // new geometry differs from last record

	assign changed = (info.hsize != hsize) |
	                 (info.vsize != vsize) |
	                 (info.res != res);

	////////////////////////////////////////////////////////////
	// capture

	always_ff @(posedge clk_28) begin
		if (!RESET) begin
			info       <= '0;
			info_count <= '0;
		end else if (vbl_end) begin
			info <= '{
				offsets: offsets,
				hsize:   hsize,
				vsize:   vsize,
				res:     res
			};
			if (changed) info_count <= info_count + 7'd1;   // offsets alone do not count
		end
	end

endmodule

//--- rtl/video_crop.sv
// video crop top level joining the shapers, key handler and info capture
`timescale 1ns/1ps

module video_crop import crop_pkg::*; (
	input  logic          clk_28,
	input  logic          RESET,
	input  logic          hsync_n,
	input  logic          vsync_n,
	input  logic          hblank,
	input  logic          vblank,
	input  logic          field1,
	input  res_t          res,
	input  key_event_t    key,
	input  crop_offsets_t preset,
	input  logic          preset_load,
	output logic          de,          // registered display enable
	output screen_info_t  info,
	output logic [6:0]    info_count
);

	crop_offsets_t offsets;      // live crop offsets
	logic          hbl;
	logic          hde;
	logic          hcnt_end;
	logic          hsize_take;
	cnt_t          hsize;
	logic          vde;
	logic          vbl_end;
	cnt_t          vsize;

	crop_keys u_keys (.clk_28, .RESET, .key, .preset, .preset_load, .offsets);

	hblank_shaper u_hbl (
		.clk_28, .RESET, .hsync_n, .hblank, .offsets, .hsize_take,
		.hbl, .hde, .hcnt_end, .hsize
	);

	vblank_shaper u_vbl (
		.clk_28, .RESET, .vsync_n, .vblank, .field1, .hbl, .hcnt_end, .offsets,
		.vde, .vbl_end, .vsize, .hsize_take
	);

	screen_info u_info (.clk_28, .RESET, .vbl_end, .offsets, .hsize, .vsize, .res,
		.info, .info_count);

	always_ff @(posedge clk_28) begin
		if (!RESET) de <= 1'b0;
		else        de <= hde & vde;   // second stage after hde
	end

endmodule

//--- tests/video_crop_asserts.sv
// concurrent checks on the video crop top level for reset, sync blanking and info counter
`timescale 1ns/1ps

module video_crop_asserts (
	input logic       clk_28,
	input logic       RESET,
	input logic       hsync_n,
	input logic       de,
	input logic       vbl_end,      // internal capture strobe
	input logic [6:0] info_count
);

	de_after_reset: assert property (@(posedge clk_28) !RESET |=> !de)
		else $error("de high one cycle after reset");

	de_in_sync: assert property (@(posedge clk_28) disable iff (!RESET)
		!hsync_n |-> ##2 !de)
		else $error("de high two cycles after hsync_n low");

	// counter moves by one, and only right after a capture strobe
	count_step: assert property (@(posedge clk_28) disable iff (!RESET)
		(info_count != $past(info_count)) |->
		(info_count == $past(info_count) + 7'd1) && $past(vbl_end))
		else $error("info_count changed outside a capture or by more than one");

endmodule

bind video_crop video_crop_asserts u_asserts (
	.clk_28(clk_28), .RESET(RESET), .hsync_n(hsync_n), .de(de),
	.vbl_end(vbl_end), .info_count(info_count)
);

//--- tests/tb_video_crop.sv
// testbench for the video crop top level with a frame generator and a stimulus table
`timescale 1ns/1ps

module tb_video_crop import crop_pkg::*; ();

	typedef struct {
		string      name;
		logic [7:0] code;   // key code, 0 for none
		bit         pre;    // random preset instead of key
		int         w;      // total pixels per line
		int         nl;     // lines per field
		bit         il;     // interlaced field pairs
		logic [1:0] res;
		int         ew;     // de width at zero preset
		int         er;     // de rows at zero preset
		int         ehs;
		int         evs;
		int         dcnt;   // expected info_count steps
	} entry_t;

	logic          clk_28 = 1'b0;
	logic          RESET, hsync_n, vsync_n, hblank, vblank, field1, preset_load, de;
	res_t          res;
	key_event_t    key;
	crop_offsets_t preset;
	screen_info_t  info;
	logic [6:0]    info_count;
	logic [31:0]   lfsr = 32'h57a7_4f5f;
	entry_t        tbl [21];

	video_crop dut (.*);

	always #20 clk_28 = ~clk_28;   // 40 ns period

	initial begin
		#40_000_000;
		$display("timeout: simulation ran longer than the watchdog limit");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
			$display(">>> FAIL");
			$fatal(1, "first mismatch");
		end
	endtask

	// one pixel clock, inputs changed just after the edge
	task automatic tick(input bit hs, input bit hb, input bit vs, input bit vb, output bit d);
		@(posedge clk_28);
		#2;
		hsync_n = hs;
		hblank  = hb;
		vsync_n = vs;
		vblank  = vb;
		d       = de;
	endtask

	task automatic idle(input int n);
		bit d;
		repeat (n) tick(1'b1, 1'b1, 1'b0, 1'b1, d);   // blank, in vsync
	endtask

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		logic        b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], b};
			v    = {v[30:0], b};
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// frame generator

	task automatic run_line(input int l, input int w, input int nl, output int cnt);
		bit d;
		cnt = 0;
		for (int p = 0; p < w; p++) begin
			tick(p >= 4, (p < 20) || (p >= w - 16), l >= 2, (l < 6) || (l >= nl - 6), d);
			cnt += d;
		end
	endtask

	task automatic run_field(input entry_t e, input bit f1, input bit meas,
			input int ew, input int er);
		int cnt;
		int nrows;
		nrows  = 0;
		field1 = f1;
		for (int l = 0; l < e.nl; l++) begin
			run_line(l, e.w, e.nl, cnt);
			if (cnt > 0) begin
				nrows++;
				if (meas) check({e.name, " width"}, ew, cnt);
			end
		end
		if (meas) check({e.name, " rows"}, er, nrows);
	endtask

	task automatic apply_event(input entry_t e, output crop_offsets_t po);
		po = '0;
		if (e.pre) begin
			po.left     = cnt_t'(random_bits(3));   // margins keep rule valid
			po.right    = cnt_t'(random_bits(3));
			po.top      = cnt_t'(random_bits(2));
			po.bottom   = cnt_t'(random_bits(2));
			preset      = po;
			preset_load = 1'b1;
			idle(1);
			preset_load = 1'b0;
			idle(1);
		end else if (e.code != 8'h00) begin
			key = '{strobe: 1'b1, kind: KIND_ADJUST, code: e.code};
			idle(2);
			key.strobe = 1'b0;
			idle(2);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus table

	task automatic fill_table();
		// first capture still sees the reset height
		tbl[0]  = '{"zero",        8'h00,        0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 2};
		tbl[1]  = '{"up",          KEY_UP,       0, 100, 40, 0, 2'd0, 64, 27, 64, 28, 0};
		tbl[2]  = '{"down",        KEY_DOWN,     0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[3]  = '{"alt_press",   KEY_ALT_L_DN, 0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[4]  = '{"alt_up",      KEY_UP,       0, 100, 40, 0, 2'd0, 64, 29, 64, 28, 0};
		tbl[5]  = '{"alt_down",    KEY_DOWN,     0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[6]  = '{"alt_left",    KEY_LEFT,     0, 100, 40, 0, 2'd0, 68, 28, 64, 28, 0};
		tbl[7]  = '{"alt_right",   KEY_RIGHT,    0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[8]  = '{"alt_release", KEY_ALT_R_UP, 0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[9]  = '{"left",        KEY_LEFT,     0, 100, 40, 0, 2'd0, 60, 28, 64, 28, 0};
		tbl[10] = '{"right",       KEY_RIGHT,    0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[11] = '{"left_again",  KEY_LEFT,     0, 100, 40, 0, 2'd0, 60, 28, 64, 28, 0};
		tbl[12] = '{"bksp",        KEY_BKSP,     0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[13] = '{"preset",      8'h00,        1, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[14] = '{"bksp_preset", KEY_BKSP,     0, 100, 40, 0, 2'd0, 64, 28, 64, 28, 0};
		tbl[15] = '{"wide",        8'h00,        0, 120, 40, 0, 2'd0, 84, 28, 84, 28, 1};
		tbl[16] = '{"tall",        8'h00,        0, 120, 50, 0, 2'd0, 84, 38, 84, 38, 1};
		tbl[17] = '{"res_one",     8'h00,        0, 120, 50, 0, 2'd1, 84, 38, 84, 38, 1};
		// field pair passes through a single field height first
		tbl[18] = '{"interlace",   8'h00,        0, 120, 40, 1, 2'd1, 84, 28, 84, 56, 2};
		tbl[19] = '{"progressive", 8'h00,        0, 120, 50, 0, 2'd1, 84, 38, 84, 38, 2};
		tbl[20] = '{"same",        8'h00,        0, 120, 50, 0, 2'd1, 84, 38, 84, 38, 0};
	endtask

	initial begin
		entry_t        e;
		crop_offsets_t po;
		logic [6:0]    start;
		int            ew;
		int            er;
		RESET       = 1'b0;
		hsync_n     = 1'b1;
		vsync_n     = 1'b1;
		hblank      = 1'b1;
		vblank      = 1'b1;
		field1      = 1'b0;
		res         = '0;
		key         = '0;
		preset      = '0;
		preset_load = 1'b0;
		repeat (16) @(posedge clk_28);
		#2;
		RESET = 1'b1;
		check("reset de", 0, de);
		check("reset info", 0, info);
		check("reset count", 0, info_count);
		fill_table();

		for (int i = 0; i < 21; i++) begin
			e     = tbl[i];
			res   = e.res;
			start = info_count;
			apply_event(e, po);
			ew = e.ew - po.left + po.right;      // horizontal rule
			er = e.er - po.top + po.bottom;      // vertical rule
			for (int f = 0; f < 3; f++) begin   // two frames to settle
				run_field(e, 1'b0, f == 2, ew, er);
				if (e.il) run_field(e, 1'b1, f == 2, ew, er);
			end
			check({e.name, " hsize"}, e.ehs, info.hsize);
			check({e.name, " vsize"}, e.evs, info.vsize);
			check({e.name, " res"}, e.res, info.res);
			check({e.name, " count"}, start + 7'(e.dcnt), info_count);
			if (e.pre) check({e.name, " offsets"}, po, info.offsets);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

//--- all.f
rtl/crop_pkg.sv
rtl/hblank_shaper.sv
rtl/vblank_shaper.sv
rtl/crop_keys.sv
rtl/screen_info.sv
rtl/video_crop.sv
tests/video_crop_asserts.sv
tests/tb_video_crop.sv
